// File: verilog/csr_pkg.sv
/*
 * Shared widths, CSR addresses and the structs of the CSR issue path.
 * Only four machine CSRs are implemented. Any other address reads zero.
 * fifo_depth must stay a power of two, since the queue pointers wrap freely.
 */
package csr_pkg;

	localparam int xlen       = 64;
	localparam int nreg       = 32;
	localparam int reg_idx_w  = 5;
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	localparam int fifo_cnt_w = fifo_ptr_w + 1;

	localparam logic [11:0] csr_mtvec    = 12'h305;
	localparam logic [11:0] csr_mscratch = 12'h340;
	localparam logic [11:0] csr_mepc     = 12'h341;
	localparam logic [11:0] csr_mcause   = 12'h342;

	typedef enum logic [1:0] {
		op_rw = 2'd0,
		op_rs = 2'd1,
		op_rc = 2'd2
	} csr_op_e;

	// the rs1 field is either a register index or a 5-bit immediate.
	typedef union packed {
		logic [reg_idx_w-1:0] reg_idx;
		logic [reg_idx_w-1:0] zimm;
	} csr_src_u;

	typedef struct packed {
		csr_op_e              op;
		logic                 imm_form;
		logic [11:0]          addr;
		logic [reg_idx_w-1:0] rd;
		csr_src_u             src;
	} csr_info_t;

	typedef struct packed {
		csr_op_e              op;
		logic [reg_idx_w-1:0] rd;
		logic [xlen-1:0]      opnd;
		logic [11:0]          addr;
	} csr_exeparam_t;

	typedef struct packed {
		logic [reg_idx_w-1:0] rd;
		logic [xlen-1:0]      data;
	} csr_result_t;

	typedef struct packed {
		logic [reg_idx_w-1:0] idx;
		logic [xlen-1:0]      data;
	} reg_wb_t;

endpackage

// File: verilog/csr_issue_fifo.sv
/*
 * In-order queue of decoded CSR instructions.
 * A push while full is dropped, so the source must watch full.
 * A pop while empty is ignored. The head is read straight from storage.
 */
`timescale 1ns/10ps

module csr_issue_fifo (
	input  logic                  CLK,
	input  logic                  arst_n,
	input  logic                  push,
	input  csr_pkg::csr_info_t    push_info,
	input  logic                  pop,
	output csr_pkg::csr_info_t    head,
	output logic                  empty,
	output logic                  full
);
	import csr_pkg::*;

	csr_info_t mem [fifo_depth];

	logic [fifo_ptr_w-1:0] rptr;
	logic [fifo_ptr_w-1:0] wptr;
	logic [fifo_cnt_w-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;
	assign empty   = (count == '0);
	assign full    = (count == fifo_cnt_w'(fifo_depth));
	assign head    = mem[rptr];

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wptr] <= push_info;
		end
	end

	// pointers wrap on their own width.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rptr  <= '0;
			wptr  <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wptr <= wptr + 1'b1;
			end
			if (do_pop) begin
				rptr <= rptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: verilog/csr_regfile.sv
/*
 * Integer register file with one ready bit per register.
 * A claim clears the ready bit, a write stores data and sets it again.
 * The CSR result beats the outside writeback on the same register, and a
 * claim beats a write. Reads are combinational and do not forward writes.
 * x0 reads zero and is always ready.
 */
`timescale 1ns/10ps

module csr_regfile (
	input  logic                               CLK,
	input  logic                               arst_n,
	input  logic [csr_pkg::reg_idx_w-1:0]      rs_idx,
	output logic [csr_pkg::xlen-1:0]           rs_data,
	output logic                               rs_ready,
	input  logic                               claim_valid,
	input  logic [csr_pkg::reg_idx_w-1:0]      claim_idx,
	input  logic                               rd_claim_valid,
	input  logic [csr_pkg::reg_idx_w-1:0]      rd_claim_idx,
	input  logic                               wb_valid,
	input  csr_pkg::reg_wb_t                   wb,
	input  logic                               csr_wb_valid,
	input  csr_pkg::csr_result_t               csr_wb
);
	import csr_pkg::*;

	logic [nreg-1:0][xlen-1:0] regs;
	logic [nreg-1:0]           ready_log;

	assign rs_data  = regs[rs_idx];
	assign rs_ready = ready_log[rs_idx];

	// entry 0 is left out of the update loop and keeps its reset value.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			regs      <= '0;
			ready_log <= '1;
		end else begin
			for (int i = 1; i < nreg; i++) begin
				logic csr_hit;
				logic wb_hit;
				logic claim_hit;

				csr_hit   = csr_wb_valid & (csr_wb.rd == reg_idx_w'(i));
				wb_hit    = wb_valid & (wb.idx == reg_idx_w'(i));
				claim_hit = (claim_valid & (claim_idx == reg_idx_w'(i)))
				          | (rd_claim_valid & (rd_claim_idx == reg_idx_w'(i)));

				if (csr_hit) begin
					regs[i] <= csr_wb.data;
				end else if (wb_hit) begin
					regs[i] <= wb.data;
				end

				if (claim_hit) begin
					ready_log[i] <= 1'b0;
				end else if (csr_hit | wb_hit) begin
					ready_log[i] <= 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/csr_issue.sv
/*
 * Issue control for CSR instructions.
 * The head issues once its source is ready (or it is immediate form) and
 * commit reports all older instructions retired. The execute word follows
 * one cycle later. Two in-flight writes to the same rd are not interlocked,
 * so a read of that rd between them may see the older value.
 */
`timescale 1ns/10ps

module csr_issue (
	input  logic                               CLK,
	input  logic                               arst_n,
	input  csr_pkg::csr_info_t                 head,
	input  logic                               fifo_empty,
	output logic                               fifo_pop,
	output logic [csr_pkg::reg_idx_w-1:0]      rs_idx,
	input  logic [csr_pkg::xlen-1:0]           rs_data,
	input  logic                               rs_ready,
	input  logic                               csr_ilp_ready,
	output logic                               rd_claim_valid,
	output logic [csr_pkg::reg_idx_w-1:0]      rd_claim_idx,
	output logic                               exeparam_valid,
	output csr_pkg::csr_exeparam_t             exeparam
);
	import csr_pkg::*;

	logic          src_ok;
	logic          issue;
	logic [xlen-1:0] opnd;
	csr_exeparam_t exeparam_nxt;

	// immediate form has no RAW hazard.
	assign rs_idx = head.src.reg_idx;
	assign src_ok = head.imm_form | rs_ready;
	assign issue  = ~fifo_empty & src_ok & csr_ilp_ready;

	assign fifo_pop = issue;

	// x0 is never marked pending.
	assign rd_claim_valid = issue & (head.rd != '0);
	assign rd_claim_idx   = head.rd;

	assign opnd = head.imm_form ? {{(xlen - reg_idx_w){1'b0}}, head.src.zimm} : rs_data;

	assign exeparam_nxt.op   = head.op;
	assign exeparam_nxt.rd   = head.rd;
	assign exeparam_nxt.opnd = opnd;
	assign exeparam_nxt.addr = head.addr;

	always_ff @(posedge CLK) begin
		if (issue) begin
			exeparam <= exeparam_nxt;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			exeparam_valid <= 1'b0;
		end else begin
			exeparam_valid <= issue;
		end
	end

endmodule

// File: verilog/csr_file.sv
/*
 * Machine-mode CSR storage for mscratch, mepc, mcause and mtvec.
 * Performs the read-modify-write of one execute word per cycle and returns
 * the old value as a registered result. An unknown address reads zero and
 * the write is dropped. No privilege checks and no CSR side effects.
 */
`timescale 1ns/10ps

module csr_file (
	input  logic                      CLK,
	input  logic                      arst_n,
	input  logic                      exeparam_valid,
	input  csr_pkg::csr_exeparam_t    exeparam,
	output logic                      res_valid,
	output csr_pkg::csr_result_t      res
);
	import csr_pkg::*;

	logic [xlen-1:0] mscratch;
	logic [xlen-1:0] mepc;
	logic [xlen-1:0] mcause;
	logic [xlen-1:0] mtvec;
	logic [xlen-1:0] old_val;
	logic [xlen-1:0] new_val;
	logic            hit;

	// address decode.
	always_comb begin
		hit     = 1'b1;
		old_val = '0;
		case (exeparam.addr)
			csr_mscratch: old_val = mscratch;
			csr_mepc:     old_val = mepc;
			csr_mcause:   old_val = mcause;
			csr_mtvec:    old_val = mtvec;
			default:      hit = 1'b0;
		endcase
	end

	always_comb begin
		case (exeparam.op)
			op_rw:   new_val = exeparam.opnd;
			op_rs:   new_val = old_val | exeparam.opnd;
			op_rc:   new_val = old_val & ~exeparam.opnd;
			default: new_val = old_val;
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			mscratch <= '0;
			mepc     <= '0;
			mcause   <= '0;
			mtvec    <= '0;
		end else if (exeparam_valid && hit) begin
			case (exeparam.addr)
				csr_mscratch: mscratch <= new_val;
				csr_mepc:     mepc     <= new_val;
				csr_mcause:   mcause   <= new_val;
				csr_mtvec:    mtvec    <= new_val;
				default:      mscratch <= mscratch;
			endcase
		end
	end

	// result carries the value seen before the update.
	always_ff @(posedge CLK) begin
		if (exeparam_valid) begin
			res.rd   <= exeparam.rd;
			res.data <= old_val;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= exeparam_valid;
		end
	end

endmodule

// File: verilog/csr_unit_top.sv
/*
 * CSR issue and execute path: queue, issue control, register file and
 * CSR file. Results go out on res and back into the register file.
 * enq_valid while fifo_full is high is dropped.
 */
`timescale 1ns/10ps

module csr_unit_top (
	input  logic                               CLK,
	input  logic                               arst_n,
	input  logic                               enq_valid,
	input  csr_pkg::csr_info_t                 enq_info,
	output logic                               fifo_full,
	input  logic                               claim_valid,
	input  logic [csr_pkg::reg_idx_w-1:0]      claim_idx,
	input  logic                               wb_valid,
	input  csr_pkg::reg_wb_t                   wb,
	input  logic                               csr_ilp_ready,
	output logic                               res_valid,
	output csr_pkg::csr_result_t               res
);
	import csr_pkg::*;

	csr_info_t            head;
	logic                 fifo_empty;
	logic                 fifo_pop;
	logic [reg_idx_w-1:0] rs_idx;
	logic [xlen-1:0]      rs_data;
	logic                 rs_ready;
	logic                 rd_claim_valid;
	logic [reg_idx_w-1:0] rd_claim_idx;
	logic                 exeparam_valid;
	csr_exeparam_t        exeparam;

	csr_issue_fifo csr_issue_fifo_i (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.push      (enq_valid),
		.push_info (enq_info),
		.pop       (fifo_pop),
		.head      (head),
		.empty     (fifo_empty),
		.full      (fifo_full)
	);

	csr_issue csr_issue_i (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.head           (head),
		.fifo_empty     (fifo_empty),
		.fifo_pop       (fifo_pop),
		.rs_idx         (rs_idx),
		.rs_data        (rs_data),
		.rs_ready       (rs_ready),
		.csr_ilp_ready  (csr_ilp_ready),
		.rd_claim_valid (rd_claim_valid),
		.rd_claim_idx   (rd_claim_idx),
		.exeparam_valid (exeparam_valid),
		.exeparam       (exeparam)
	);

	csr_regfile csr_regfile_i (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.rs_idx         (rs_idx),
		.rs_data        (rs_data),
		.rs_ready       (rs_ready),
		.claim_valid    (claim_valid),
		.claim_idx      (claim_idx),
		.rd_claim_valid (rd_claim_valid),
		.rd_claim_idx   (rd_claim_idx),
		.wb_valid       (wb_valid),
		.wb             (wb),
		.csr_wb_valid   (res_valid),
		.csr_wb         (res)
	);

	csr_file csr_file_i (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.exeparam_valid (exeparam_valid),
		.exeparam       (exeparam),
		.res_valid      (res_valid),
		.res            (res)
	);

endmodule

// File: verif/csr_tb_vectors.svh
/*
 * Stimulus table for the CSR unit testbench, one row per CSR instruction.
 * Writeback data is not in the table. It comes from the LFSR at run time.
 * A row with a claim or a writeback waits until earlier results are back.
 * Expected old values come from the reference model. The table gives rd.
 */
`ifndef csr_tb_vectors_svh
`define csr_tb_vectors_svh

localparam logic [11:0] csr_unimpl = 12'h7c0;

typedef struct packed {
	logic                 claim;
	logic                 wb;
	logic [reg_idx_w-1:0] ridx;
	csr_op_e              op;
	logic                 imm;
	logic [11:0]          addr;
	logic [reg_idx_w-1:0] rd;
	logic [reg_idx_w-1:0] src;
	logic [7:0]           ilp_low;
	logic [reg_idx_w-1:0] exp_rd;
	logic [reg_idx_w-1:0] chk_reg;
} vec_t;

localparam int num_vecs = 35;

// claim wb ridx | op imm addr rd src | ilp_low | exp_rd chk_reg.
localparam vec_t vectors [num_vecs] = '{
	'{0, 1, 1, op_rw, 0, csr_mscratch,  0,  1,  0,  0,  0},
	'{0, 1, 2, op_rs, 0, csr_mscratch,  5,  2,  0,  5,  0},
	'{0, 0, 0, op_rc, 0, csr_mscratch,  6,  1,  0,  6,  0},
	'{0, 0, 0, op_rs, 0, csr_mscratch,  7,  0,  0,  7,  0},
	'{0, 0, 0, op_rw, 0, csr_mepc,      8,  2,  0,  8,  0},
	'{0, 0, 0, op_rc, 0, csr_mepc,      9,  1,  0,  9,  0},
	'{0, 0, 0, op_rw, 0, csr_mcause,   10,  5,  0, 10,  0},
	'{0, 0, 0, op_rs, 0, csr_mtvec,    11,  6,  0, 11,  0},
	'{0, 0, 0, op_rc, 0, csr_mtvec,    12,  2,  0, 12,  0},
	// immediate form whose zimm matches a loaded register number.
	'{0, 0, 0, op_rw, 1, csr_mcause,   13,  1,  0, 13,  0},
	'{0, 0, 0, op_rs, 1, csr_mcause,   14,  2,  0, 14,  0},
	'{0, 0, 0, op_rc, 1, csr_mcause,   15,  1,  0, 15,  0},
	// source claimed by an outside producer.
	'{1, 1, 3, op_rw, 0, csr_mtvec,    16,  3,  0, 16,  0},
	'{1, 1, 4, op_rs, 0, csr_mepc,     17,  4,  0, 17,  0},
	// back to back dependencies and x0 as rd or source.
	'{0, 0, 0, op_rw, 0, csr_mscratch, 20,  3,  0, 20,  0},
	'{0, 0, 0, op_rw, 0, csr_mepc,     21, 20,  0, 21,  0},
	'{0, 0, 0, op_rs, 0, csr_mepc,      0, 21,  0,  0,  0},
	'{0, 0, 0, op_rw, 0, csr_mscratch,  0,  2,  0,  0,  0},
	'{0, 0, 0, op_rw, 0, csr_mtvec,    23,  0,  0, 23,  0},
	'{0, 0, 0, op_rw, 0, csr_mscratch, 24, 20,  0, 24,  0},
	'{0, 0, 0, op_rs, 0, csr_mscratch, 25,  0,  0, 25, 20},
	// commit holds issue while these queue up and fill the FIFO.
	'{0, 0, 0, op_rs, 1, csr_mepc,     26,  4, 12, 26,  0},
	'{0, 0, 0, op_rs, 0, csr_mcause,   27, 26,  0, 27,  0},
	'{0, 0, 0, op_rc, 0, csr_mepc,     28,  1,  0, 28,  0},
	'{0, 0, 0, op_rs, 1, csr_mtvec,    29,  3,  0, 29,  0},
	'{0, 0, 0, op_rw, 0, csr_mscratch, 30,  2,  0, 30,  0},
	'{0, 0, 0, op_rs, 0, csr_mscratch, 31,  0,  0, 31,  0},
	// unknown address, then every CSR read back unchanged.
	'{0, 0, 0, op_rw, 0, csr_unimpl,   18,  1,  0, 18,  0},
	'{0, 0, 0, op_rs, 1, csr_unimpl,   19, 31,  0, 19,  0},
	'{0, 0, 0, op_rs, 0, csr_mscratch,  0,  0,  0,  0,  0},
	'{0, 0, 0, op_rs, 0, csr_mepc,      0,  0,  0,  0,  0},
	'{0, 0, 0, op_rc, 0, csr_mcause,    0,  1,  0,  0,  0},
	'{0, 0, 0, op_rs, 0, csr_mtvec,     0,  0,  0,  0,  0},
	'{0, 0, 0, op_rw, 0, csr_mcause,    0, 17,  0,  0,  0},
	'{0, 0, 0, op_rs, 0, csr_mcause,    0,  0,  0,  0, 17}
};

// fibonacci LFSR with taps 32 22 2 1. The new bit lands in bit 0.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;

	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

`endif

// File: verif/csr_tb.sv
/*
 * Testbench for the CSR issue and execute path.
 * Inputs change 1 ns after the rising edge, outputs are sampled on the
 * falling edge. A reference model runs each row in program order and
 * queues the expected results, which are matched against res in order.
 */
`timescale 1ns/10ps

module csr_tb;
	import csr_pkg::*;

	`include "csr_tb_vectors.svh"

	typedef struct packed {
		csr_result_t          res;
		logic [reg_idx_w-1:0] chk_reg;
		logic [xlen-1:0]      reg_val;
	} exp_t;

	localparam int cycle_limit = 40 * num_vecs + 100;
	localparam int claim_stall = 6;

	logic                 CLK;
	logic                 arst_n;
	logic                 enq_valid;
	csr_info_t            enq_info;
	logic                 fifo_full;
	logic                 claim_valid;
	logic [reg_idx_w-1:0] claim_idx;
	logic                 wb_valid;
	reg_wb_t              wb;
	logic                 csr_ilp_ready;
	logic                 res_valid;
	csr_result_t          res;

	logic [31:0]     lfsr_state;
	logic [xlen-1:0] m_csr [4];
	logic [xlen-1:0] m_regs [nreg];
	exp_t            exp_q [$];
	int              ilp_hold;
	int              cycles;
	int              n_checks;
	int              val_errs;
	int              other_errs;
	int              res_seen;
	logic            ilp_d1;
	logic            ilp_d2;

	csr_unit_top csr_unit_top_i (
		.CLK           (CLK),
		.arst_n        (arst_n),
		.enq_valid     (enq_valid),
		.enq_info      (enq_info),
		.fifo_full     (fifo_full),
		.claim_valid   (claim_valid),
		.claim_idx     (claim_idx),
		.wb_valid      (wb_valid),
		.wb            (wb),
		.csr_ilp_ready (csr_ilp_ready),
		.res_valid     (res_valid),
		.res           (res)
	);

	always #4 CLK = ~CLK;

	function automatic logic [xlen-1:0] rand64();
		logic [xlen-1:0] v;

		v = '0;
		for (int i = 0; i < xlen; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[xlen-2:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int csr_slot(input logic [11:0] addr);
		case (addr)
			csr_mscratch: return 0;
			csr_mepc:     return 1;
			csr_mcause:   return 2;
			csr_mtvec:    return 3;
			default:      return -1;
		endcase
	endfunction

	// reference model for one instruction in program order.
	task automatic model_exec(input vec_t v);
		logic [xlen-1:0] opnd;
		logic [xlen-1:0] old;
		int              slot;
		exp_t            e;

		opnd = v.imm ? xlen'(v.src) : m_regs[v.src];
		slot = csr_slot(v.addr);
		old  = '0;
		if (slot >= 0) begin
			old = m_csr[slot];
			case (v.op)
				op_rw:   m_csr[slot] = opnd;
				op_rs:   m_csr[slot] = old | opnd;
				op_rc:   m_csr[slot] = old & ~opnd;
				default: m_csr[slot] = old;
			endcase
		end
		if (v.rd != 0) begin
			m_regs[v.rd] = old;
		end
		e.res.rd   = v.exp_rd;
		e.res.data = old;
		e.chk_reg  = v.chk_reg;
		e.reg_val  = m_regs[v.chk_reg];
		exp_q.push_back(e);
	endtask

	task automatic check_result(input csr_result_t got, input csr_result_t exp);
		n_checks++;
		if (got !== exp) begin
			val_errs++;
			$display("error at %0t ns: res got rd=%0d data=%h, expected rd=%0d data=%h",
				$time, got.rd, got.data, exp.rd, exp.data);
		end
	endtask

	task automatic check_reg(input logic [reg_idx_w-1:0] idx, input logic [xlen-1:0] got,
			input logic [xlen-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			val_errs++;
			$display("error at %0t ns: x%0d read back %h, expected %h", $time, idx, got, exp);
		end
	endtask

	// one clock and then the commit level for the coming cycle.
	task automatic step();
		@(posedge CLK);
		#1;
		if (ilp_hold > 0) begin
			csr_ilp_ready = 1'b0;
			ilp_hold--;
		end else begin
			csr_ilp_ready = 1'b1;
		end
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			step();
		end
	endtask

	task automatic push_instr(input csr_info_t info);
		while (fifo_full) begin
			step();
		end
		enq_info  = info;
		enq_valid = 1'b1;
		step();
		enq_valid = 1'b0;
	endtask

	task automatic claim_reg(input logic [reg_idx_w-1:0] idx);
		claim_idx   = idx;
		claim_valid = 1'b1;
		step();
		claim_valid = 1'b0;
	endtask

	task automatic write_back(input logic [reg_idx_w-1:0] idx, input logic [xlen-1:0] data);
		wb.idx   = idx;
		wb.data  = data;
		wb_valid = 1'b1;
		step();
		wb_valid = 1'b0;
	endtask

	task automatic report_and_finish();
		$display("checks: %0d, value errors: %0d, other errors: %0d",
			n_checks, val_errs, other_errs);
		if (val_errs + other_errs == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	// results are matched in order, and none may follow a held commit.
	always @(negedge CLK) begin
		exp_t e;

		if (arst_n) begin
			if (res_valid) begin
				res_seen++;
				if (!ilp_d2) begin
					other_errs++;
					$display("result at %0t ns issued while commit was not ready", $time);
				end
				if (exp_q.size() == 0) begin
					other_errs++;
					$display("result at %0t ns came with no instruction waiting for it", $time);
				end else begin
					e = exp_q.pop_front();
					check_result(res, e.res);
					if (e.chk_reg != 0) begin
						check_reg(e.chk_reg, res.data, e.reg_val);
					end
				end
			end
			ilp_d2 = ilp_d1;
			ilp_d1 = csr_ilp_ready;
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles == cycle_limit) begin
			other_errs++;
			$display("timeout after %0d cycles with %0d results still missing",
				cycles, exp_q.size());
			report_and_finish();
		end
	end

	initial begin
		vec_t            v;
		csr_info_t       info;
		logic [xlen-1:0] wb_data;
		int              seen0;

		CLK           = 1'b0;
		arst_n        = 1'b0;
		enq_valid     = 1'b0;
		enq_info      = '0;
		claim_valid   = 1'b0;
		claim_idx     = '0;
		wb_valid      = 1'b0;
		wb            = '0;
		csr_ilp_ready = 1'b1;
		lfsr_state    = 32'h2aa0;
		ilp_hold      = 0;
		cycles        = 0;
		n_checks      = 0;
		val_errs      = 0;
		other_errs    = 0;
		res_seen      = 0;
		ilp_d1        = 1'b1;
		ilp_d2        = 1'b1;
		for (int r = 0; r < nreg; r++) begin
			m_regs[r] = '0;
		end
		for (int c = 0; c < 4; c++) begin
			m_csr[c] = '0;
		end

		repeat (4) @(posedge CLK);
		#1;
		arst_n = 1'b1;
		if (fifo_full !== 1'b0 || res_valid !== 1'b0) begin
			other_errs++;
			$display("fifo_full or res_valid is not low after reset");
		end

		for (int i = 0; i < num_vecs; i++) begin
			v = vectors[i];
			if (v.ilp_low != 0) begin
				ilp_hold      = v.ilp_low;
				csr_ilp_ready = 1'b0;
			end
			info          = '0;
			info.op       = v.op;
			info.imm_form = v.imm;
			info.addr     = v.addr;
			info.rd       = v.rd;
			if (v.imm) begin
				info.src.zimm = v.src;
			end else begin
				info.src.reg_idx = v.src;
			end
			wb_data = v.wb ? rand64() : '0;
			if (v.wb && v.ridx != 0) begin
				m_regs[v.ridx] = wb_data;
			end
			if (v.claim || v.wb) begin
				drain();
			end
			model_exec(v);

			if (v.claim) begin
				claim_reg(v.ridx);
				push_instr(info);
				seen0 = res_seen;
				repeat (claim_stall) step();
				if (res_seen != seen0) begin
					other_errs++;
					$display("row %0d gave a result before its source was written back", i);
				end
				write_back(v.ridx, wb_data);
			end else if (v.wb) begin
				write_back(v.ridx, wb_data);
				push_instr(info);
			end else begin
				push_instr(info);
			end
		end

		drain();
		repeat (4) step();
		report_and_finish();
	end

endmodule

// File: filelist.f
+incdir+verif
verilog/csr_pkg.sv
verilog/csr_issue_fifo.sv
verilog/csr_regfile.sv
verilog/csr_issue.sv
verilog/csr_file.sv
verilog/csr_unit_top.sv
verif/csr_tb.sv
